// ==== cpuTypesPkg.sv ====
package cpuTypesPkg;

	// Architectural widths of the core.
	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;

	// Same encoding as the ExcCode field of the CP0 Cause register.
	typedef logic [4:0] excCode_t;

	localparam excCode_t excNone = 5'h00;
	localparam excCode_t excOverflow = 5'h0C;

endpackage

// ==== execOpsPkg.sv ====
package execOpsPkg;

	typedef enum logic [3:0] {
		ADD,
		ADDU,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLL,
		MULLO,
		MULHI
	} execOp_t;

	typedef enum logic {
		UNIT_ALU,
		UNIT_MUL
	} execUnit_t;

	// One decoded operation as it leaves decode.
	typedef struct packed {
		cpuTypesPkg::word_t pc;
		execOp_t op;
		cpuTypesPkg::word_t a;
		cpuTypesPkg::word_t b;
		cpuTypesPkg::regIdx_t rd;
	} opPayload_t;

	// One finished result on its way to writeback.
	typedef struct packed {
		cpuTypesPkg::word_t pc;
		cpuTypesPkg::regIdx_t rd;
		cpuTypesPkg::word_t result;
		cpuTypesPkg::excCode_t exc;
	} resPayload_t;

	function automatic execUnit_t unitOf(input execOp_t op);
		if (op == MULLO || op == MULHI) begin
			return UNIT_MUL;
		end
		return UNIT_ALU;
	endfunction

endpackage

// ==== stageLink.sv ====
interface stageLink #(
	parameter type payload_t = logic
) (
	input logic advance
);
	logic valid;
	payload_t data;

	// Producer side of a stage boundary.
	modport src (
		output valid,
		output data,
		input advance
	);

	// Consumer side.
	modport dst (
		input valid,
		input data,
		input advance
	);

endinterface

// ==== pipeStageReg.sv ====
module pipeStageReg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic inValid,
	input payload_t inData,
	output logic outValid,
	output payload_t outData
);

	// A flushed slot turns into a bubble.
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			outValid <= 1'b0;
		end else if (wr) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			outData <= inData;
		end
	end

endmodule

// ==== issueStage.sv ====
module issueStage
	import execOpsPkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic advance,
	input logic inValid,
	input opPayload_t inOp,
	output logic inReady,
	stageLink.src aluLink,
	stageLink.src mulLink
);
	logic heldValid;
	opPayload_t heldOp;
	logic toMul;

	// Nothing is taken in while the pipe is frozen or being flushed.
	assign inReady = advance && !flush;

	pipeStageReg #(
		.payload_t(opPayload_t)
	) issueReg (
		.clk(clk),
		.rst(rst),
		.wr(advance),
		.flush(flush),
		.inValid(inValid),
		.inData(inOp),
		.outValid(heldValid),
		.outData(heldOp)
	);

	assign toMul = (unitOf(heldOp.op) == UNIT_MUL);

	// Both units see the operation, only one sees it valid.
	assign aluLink.valid = heldValid && !toMul;
	assign aluLink.data = heldOp;
	assign mulLink.valid = heldValid && toMul;
	assign mulLink.data = heldOp;

endmodule

// ==== aluUnit.sv ====
module aluUnit
	import cpuTypesPkg::*, execOpsPkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic advance,
	stageLink.dst opIn,
	stageLink.src resOut
);
	word_t a;
	word_t b;
	word_t sum;
	word_t diff;
	word_t aluValue;
	logic overflow;
	resPayload_t res;

	assign a = opIn.data.a;
	assign b = opIn.data.b;
	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		aluValue = '0;
		overflow = 1'b0;
		case (opIn.data.op)
			ADD: begin
				aluValue = sum;
				overflow = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			ADDU: aluValue = sum;
			SUB: begin
				aluValue = diff;
				overflow = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			AND: aluValue = a & b;
			OR: aluValue = a | b;
			XOR: aluValue = a ^ b;
			SLT: aluValue = {31'd0, $signed(a) < $signed(b)};
			SLL: aluValue = a << b[4:0];
			default: aluValue = '0;
		endcase
	end

	// Overflow replaces the result with an exception.
	always_comb begin
		res.pc = opIn.data.pc;
		res.rd = opIn.data.rd;
		res.result = overflow ? '0 : aluValue;
		res.exc = overflow ? excOverflow : excNone;
	end

	pipeStageReg #(
		.payload_t(resPayload_t)
	) aluReg (
		.clk(clk),
		.rst(rst),
		.wr(advance),
		.flush(flush),
		.inValid(opIn.valid),
		.inData(res),
		.outValid(resOut.valid),
		.outData(resOut.data)
	);

	// Issue must never steer a multiply here.
	aluOpOnly: assert property (@(posedge clk) disable iff (!rst)
		opIn.valid |-> unitOf(opIn.data.op) == UNIT_ALU);

endmodule

// ==== mulUnit.sv ====
module mulUnit
	import cpuTypesPkg::*, execOpsPkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic advance,
	stageLink.dst opIn,
	stageLink.src resOut
);
	logic signed [63:0] product;
	word_t mulValue;
	resPayload_t res;

	// Full signed product, both operands sign extended.
	assign product = $signed(opIn.data.a) * $signed(opIn.data.b);

	assign mulValue = (opIn.data.op == MULHI) ? product[63:32] : product[31:0];

	always_comb begin
		res.pc = opIn.data.pc;
		res.rd = opIn.data.rd;
		res.result = mulValue;
		res.exc = excNone;
	end

	pipeStageReg #(
		.payload_t(resPayload_t)
	) mulReg (
		.clk(clk),
		.rst(rst),
		.wr(advance),
		.flush(flush),
		.inValid(opIn.valid),
		.inData(res),
		.outValid(resOut.valid),
		.outData(resOut.data)
	);

endmodule

// ==== writebackMerge.sv ====
module writebackMerge
	import cpuTypesPkg::*, execOpsPkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,
	stageLink.dst aluIn,
	stageLink.dst mulIn,
	input logic outReady,
	output logic advance,
	output logic outValid,
	output word_t outPc,
	output regIdx_t outRd,
	output word_t outResult,
	output excCode_t outExc
);
	logic mergedValid;
	resPayload_t merged;
	resPayload_t held;

	// The whole pipe moves whenever the output slot is free or drained.
	assign advance = !outValid || outReady;

	// Same latency in both units, so at most one result arrives per cycle.
	assign mergedValid = aluIn.valid || mulIn.valid;
	assign merged = aluIn.valid ? aluIn.data : mulIn.data;

	pipeStageReg #(
		.payload_t(resPayload_t)
	) outReg (
		.clk(clk),
		.rst(rst),
		.wr(advance),
		.flush(flush),
		.inValid(mergedValid),
		.inData(merged),
		.outValid(outValid),
		.outData(held)
	);

	assign outPc = held.pc;
	assign outRd = held.rd;
	assign outResult = held.result;
	assign outExc = held.exc;

	// Issue raises valid toward one unit only.
	oneUnitValid: assert property (@(posedge clk) disable iff (!rst)
		!(aluIn.valid && mulIn.valid));

	// A stalled result stays put until taken
	outStableOnStall: assert property (@(posedge clk) disable iff (!rst)
		outValid && !outReady && !flush |=> outValid && $stable(held));

endmodule

// ==== execCluster.sv ====
module execCluster
	import cpuTypesPkg::*, execOpsPkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic inValid,
	input word_t inPc,
	input execOp_t inOp,
	input word_t inA,
	input word_t inB,
	input regIdx_t inRd,
	input logic outReady,
	output logic inReady,
	output logic outValid,
	output word_t outPc,
	output regIdx_t outRd,
	output word_t outResult,
	output excCode_t outExc
);
	logic advance;
	opPayload_t inPayload;

	stageLink #(.payload_t(opPayload_t)) aluLink (.advance(advance));
	stageLink #(.payload_t(opPayload_t)) mulLink (.advance(advance));
	stageLink #(.payload_t(resPayload_t)) aluRes (.advance(advance));
	stageLink #(.payload_t(resPayload_t)) mulRes (.advance(advance));

	assign inPayload = '{pc: inPc, op: inOp, a: inA, b: inB, rd: inRd};

	issueStage issue (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.advance(advance),
		.inValid(inValid),
		.inOp(inPayload),
		.inReady(inReady),
		.aluLink(aluLink.src),
		.mulLink(mulLink.src)
	);

	aluUnit alu (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.advance(advance),
		.opIn(aluLink.dst),
		.resOut(aluRes.src)
	);

	mulUnit mul (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.advance(advance),
		.opIn(mulLink.dst),
		.resOut(mulRes.src)
	);

	writebackMerge merge (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.aluIn(aluRes.dst),
		.mulIn(mulRes.dst),
		.outReady(outReady),
		.advance(advance),
		.outValid(outValid),
		.outPc(outPc),
		.outRd(outRd),
		.outResult(outResult),
		.outExc(outExc)
	);

endmodule

// ==== execChecker.sv ====
module execChecker
	import cpuTypesPkg::*, execOpsPkg::*;
(
	input logic clk, rst, flush,
	input logic inValid, inReady,
	input word_t inPc,
	input execOp_t inOp,
	input regIdx_t inRd,
	input word_t expResult,
	input excCode_t expExc,
	input logic outValid, outReady,
	input word_t outPc, outResult,
	input regIdx_t outRd,
	input excCode_t outExc,
	input logic done,
	output int errors, pending, dropped,
	output logic reported
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		word_t pc;
		execOp_t op;
		regIdx_t rd;
		word_t result;
		excCode_t exc;
		logic [31:0] mark;
	} expected_t;

	expected_t expq[$];
	expected_t front;
	int advEdges = 0;
	int accepted = 0;
	int matched = 0;
	int mismatched = 0;
	int errorCount = 0;
	int droppedCount = 0;
	int pendingCount = 0;
	logic reportDone = 1'b0;
	logic prevAdvance = 1'b1;
	logic prevStall = 1'b0;
	logic prevFlush = 1'b0;
	logic inReset = 1'b1;
	logic frontBad = 1'b0;
	logic adv;
	word_t lastPc;
	word_t lastResult;
	regIdx_t lastRd;
	excCode_t lastExc;

	assign errors = errorCount;
	assign pending = pendingCount;
	assign dropped = droppedCount;
	assign reported = reportDone;

	function automatic string unitName(input execOp_t op);
		return (unitOf(op) == UNIT_MUL) ? "mul" : "alu";
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("error: %s is 0x%h, expected 0x%h", name, got, want);
			errorCount++;
			frontBad = 1'b1;
		end
	endtask

	task automatic reportProblem(input string what);
		$display("error: %s", what);
		errorCount++;
	endtask

	// Ports are sampled between edges, where every input and output is settled.
	always @(negedge clk) begin
		if (!rst) begin
			expq.delete();
			prevAdvance = 1'b1;
			prevStall = 1'b0;
			prevFlush = 1'b0;
			inReset = 1'b1;
		end else begin
			if (inReset && outValid !== 1'b0) begin
				reportProblem("outValid is not 0 after reset");
			end
			inReset = 1'b0;
			adv = !outValid || outReady;
			if (inReady !== (adv && !flush)) begin
				$display("error: inReady is 0x%h, expected 0x%h", inReady, adv && !flush);
				errorCount++;
			end
			if (prevFlush && outValid) begin
				reportProblem("outValid is high right after a flush");
			end
			if (prevStall) begin
				if (!outValid) begin
					reportProblem("outValid dropped while the output was stalled");
				end
				checkValue("outPc while stalled", outPc, lastPc);
				checkValue("outRd while stalled", 32'(outRd), 32'(lastRd));
				checkValue("outResult while stalled", outResult, lastResult);
				checkValue("outExc while stalled", 32'(outExc), 32'(lastExc));
			end
			// A result freshly loaded into the output register.
			if (outValid && prevAdvance) begin
				if (expq.size() == 0) begin
					reportProblem("outValid raised with no operation in flight");
				end else begin
					front = expq[0];
					frontBad = 1'b0;
					checkValue("outPc", outPc, front.pc);
					checkValue("outRd", 32'(outRd), 32'(front.rd));
					checkValue("outResult", outResult, front.result);
					checkValue("outExc", 32'(outExc), 32'(front.exc));
					if (advEdges - int'(front.mark) != 2) begin
						$display("error: pc 0x%h came out after %0d advancing edges instead of 3",
							front.pc, advEdges - int'(front.mark) + 1);
						errorCount++;
						frontBad = 1'b1;
					end
				end
			end
			if (outValid && outReady && expq.size() > 0) begin
				front = expq.pop_front();
				if (frontBad) begin
					mismatched++;
				end else begin
					matched++;
				end
				$display("row %0d %s pc 0x%h rd %0d result 0x%h exc 0x%h: %s", front.pc / 4,
					unitName(front.op), outPc, outRd, outResult, outExc,
					frontBad ? "mismatch" : "ok");
			end
			if (flush) begin
				droppedCount += expq.size();
				expq.delete();
			end
			if (adv) begin
				advEdges++;
			end
			if (inValid && inReady) begin
				expq.push_back('{pc: inPc, op: inOp, rd: inRd, result: expResult, exc: expExc,
					mark: 32'(advEdges)});
				accepted++;
			end
			prevStall = outValid && !outReady && !flush;
			prevAdvance = adv;
			prevFlush = flush;
			lastPc = outPc;
			lastRd = outRd;
			lastResult = outResult;
			lastExc = outExc;
			pendingCount = expq.size();
			if (done && !reportDone) begin
				$display("accepted %0d, matched %0d, mismatched %0d, dropped by flush %0d, errors %0d",
					accepted, matched, mismatched, droppedCount, errorCount);
				reportDone = 1'b1;
			end
		end
	end

endmodule

// ==== execCluster_tb.sv ====
module execCluster_tb
	import cpuTypesPkg::*, execOpsPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		execOp_t op;
		word_t a;
		word_t b;
		regIdx_t rd;
		word_t expResult;
		excCode_t expExc;
	} row_t;

	localparam int numRows = 15;
	localparam int resetCycles = 10;
	localparam int flushTestCycles = 40;
	localparam int stallFactor = 4;
	localparam int timeoutLimit = resetCycles + numRows * 3 + numRows * 3 * stallFactor
		+ flushTestCycles;

	logic clk = 1'b0;
	logic rst, flush, inValid, inReady, outValid, done, reported;
	logic outReady = 1'b0;
	logic randomReady = 1'b0;
	logic [15:0] lfsr = 16'h0001;
	word_t inPc, inA, inB, outPc, outResult, expResult;
	execOp_t inOp;
	regIdx_t inRd, outRd;
	excCode_t outExc, expExc;
	int errors, pending, dropped;
	int tbErrors = 0;
	int cycles = 0;
	row_t rows [numRows];

	execCluster dut (
		.clk(clk), .rst(rst), .flush(flush), .inValid(inValid), .inPc(inPc), .inOp(inOp),
		.inA(inA), .inB(inB), .inRd(inRd), .outReady(outReady), .inReady(inReady),
		.outValid(outValid), .outPc(outPc), .outRd(outRd), .outResult(outResult),
		.outExc(outExc)
	);

	execChecker scoreboard (
		.clk(clk), .rst(rst), .flush(flush), .inValid(inValid), .inReady(inReady),
		.inPc(inPc), .inOp(inOp), .inRd(inRd), .expResult(expResult), .expExc(expExc),
		.outValid(outValid), .outReady(outReady), .outPc(outPc), .outResult(outResult),
		.outRd(outRd), .outExc(outExc), .done(done), .errors(errors), .pending(pending),
		.dropped(dropped), .reported(reported)
	);

	always #10 clk = ~clk;

	// Fibonacci LFSR, taps 16 14 13 11.
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		logic fb;
		fb = state[0] ^ state[2] ^ state[3] ^ state[5];
		return {fb, state[15:1]};
	endfunction

	always @(posedge clk) begin
		if (randomReady) begin
			outReady <= lfsr[0];
			lfsr <= lfsrStep(lfsr);
		end else begin
			outReady <= 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeoutLimit) begin
			$display("timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic driveRow(input int idx);
		inValid <= 1'b1;
		inPc <= word_t'(idx * 4);
		inOp <= rows[idx].op;
		inA <= rows[idx].a;
		inB <= rows[idx].b;
		inRd <= rows[idx].rd;
		expResult <= rows[idx].expResult;
		expExc <= rows[idx].expExc;
	endtask

	// Called on a rising edge, returns on the edge that takes the row.
	task automatic sendRow(input int idx);
		driveRow(idx);
		@(negedge clk);
		while (!inReady) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic waitDrained();
		while (pending != 0) begin
			@(posedge clk);
		end
	endtask

	initial begin
		rst = 1'b0;
		flush = 1'b0;
		inValid = 1'b0;
		inPc = '0;
		inOp = ADD;
		inA = '0;
		inB = '0;
		inRd = '0;
		expResult = '0;
		expExc = excNone;
		done = 1'b0;
		rows[0] = '{ADDU, 32'h7fffffff, 32'h00000001, 5'd1, 32'h80000000, excNone};
		rows[1] = '{AND, 32'hf0f01234, 32'h0ff0ffff, 5'd2, 32'h00f01234, excNone};
		rows[2] = '{OR, 32'hf0000000, 32'h000000a5, 5'd3, 32'hf00000a5, excNone};
		rows[3] = '{XOR, 32'haaaa5555, 32'hffff0000, 5'd4, 32'h55555555, excNone};
		rows[4] = '{SLT, 32'hfffffffb, 32'h00000003, 5'd5, 32'h00000001, excNone};
		rows[5] = '{SLT, 32'hfffffffe, 32'hfffffff9, 5'd6, 32'h00000000, excNone};
		rows[6] = '{SLL, 32'h00000001, 32'h00000024, 5'd7, 32'h00000010, excNone};
		rows[7] = '{ADD, 32'h7fffffff, 32'h00000001, 5'd8, 32'h00000000, excOverflow};
		rows[8] = '{ADD, 32'h80000000, 32'hffffffff, 5'd9, 32'h00000000, excOverflow};
		rows[9] = '{ADD, 32'h00000064, 32'hffffffe2, 5'd10, 32'h00000046, excNone};
		rows[10] = '{SUB, 32'h80000000, 32'h00000001, 5'd11, 32'h00000000, excOverflow};
		rows[11] = '{SUB, 32'h00000005, 32'h00000009, 5'd12, 32'hfffffffc, excNone};
		rows[12] = '{MULLO, 32'hfffffffd, 32'h00000007, 5'd13, 32'hffffffeb, excNone};
		rows[13] = '{MULHI, 32'hfffffffd, 32'h00000007, 5'd14, 32'hffffffff, excNone};
		rows[14] = '{MULHI, 32'h80000000, 32'h80000000, 5'd15, 32'h40000000, excNone};
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b1;
		// Whole table under random back-pressure.
		randomReady <= 1'b1;
		for (int i = 0; i < numRows; i++) begin
			sendRow(i);
		end
		inValid <= 1'b0;
		waitDrained();
		// Back-to-back with the output always taken.
		randomReady <= 1'b0;
		repeat (2) @(posedge clk);
		for (int i = 0; i < numRows; i++) begin
			sendRow(i);
		end
		inValid <= 1'b0;
		waitDrained();
		// Two rows in flight, a third offered together with the flush.
		sendRow(0);
		sendRow(1);
		driveRow(2);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		inValid <= 1'b0;
		repeat (6) @(posedge clk);
		if (dropped != 2) begin
			$display("error: the flush dropped %0d operations instead of 2", dropped);
			tbErrors++;
		end
		sendRow(3);
		sendRow(4);
		inValid <= 1'b0;
		waitDrained();
		done <= 1'b1;
		while (!reported) begin
			@(posedge clk);
		end
		if (errors == 0 && tbErrors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== execCluster.f ====
cpuTypesPkg.sv
execOpsPkg.sv
stageLink.sv
pipeStageReg.sv
issueStage.sv
aluUnit.sv
mulUnit.sv
writebackMerge.sv
execCluster.sv
execChecker.sv
execCluster_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
TOP = execCluster_tb
RTL_TOP = execCluster
FILELIST = execCluster.f
OBJ_DIR = obj_dir
PASS_MSG = >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
